/* src/alu_pkg.sv */
// Package: word width, word and count types, ALU opcode enum, request and response structs
`default_nettype none

package alu_pkg;

  // Data word width, fixed by RV32
  localparam int XLEN = 32;

  // One data word
  typedef logic [XLEN-1:0] word_t;

  // Bit counter result, 0 to 32
  typedef logic [5:0] count_t;

  // Opcodes, encodings are fixed
  typedef enum logic [5:0] {
    ALU_AND    = 6'd0,
    ALU_OR     = 6'd1,
    ALU_XOR    = 6'd2,
    ALU_ADD    = 6'd3,
    ALU_SUB    = 6'd4,
    ALU_SLL    = 6'd5,
    ALU_SRL    = 6'd6,
    ALU_SRA    = 6'd7,
    ALU_SLTS   = 6'd8,
    ALU_SLTU   = 6'd9,
    ALU_EQ     = 6'd10,
    ALU_NE     = 6'd11,
    ALU_GES    = 6'd12,
    ALU_GEU    = 6'd13,
    ALU_LTS    = 6'd14,
    ALU_LTU    = 6'd15,
    ALU_SH1ADD = 6'd16,
    ALU_SH2ADD = 6'd17,
    ALU_SH3ADD = 6'd18,
    ALU_CLZ    = 6'd19,
    ALU_CTZ    = 6'd20,
    ALU_CPOP   = 6'd21,
    ALU_MIN    = 6'd22,
    ALU_MINU   = 6'd23,
    ALU_MAX    = 6'd24,
    ALU_MAXU   = 6'd25,
    ALU_ANDN   = 6'd26,
    ALU_ORN    = 6'd27,
    ALU_XNOR   = 6'd28,
    ALU_ORC_B  = 6'd29,
    ALU_REV8   = 6'd30,
    ALU_ROL    = 6'd31,
    ALU_ROR    = 6'd32,
    ALU_SEXT_B = 6'd33,
    ALU_SEXT_H = 6'd34,
    ALU_BSET   = 6'd35,
    ALU_BCLR   = 6'd36,
    ALU_BINV   = 6'd37,
    ALU_BEXT   = 6'd38
  } alu_op_e;

  // Request into the ALU, 70 bits
  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
  } alu_req_t;

  // Registered response, 33 bits
  typedef struct packed {
    word_t result;
    logic  cmp;
  } alu_rsp_t;

endpackage

`default_nettype wire

/* src/alu_shifter.sv */
// Funnel shifter for shifts, rotates and Zbs single-bit operations
`timescale 1ns/1ps
`default_nettype none

module alu_shifter (
  input  alu_pkg::alu_req_t req_i,
  output alu_pkg::word_t    shift_result_o,
  output alu_pkg::word_t    bit_result_o
);
  import alu_pkg::*;

  // Controls decoded from the opcode
  logic        rshift;
  logic        arithmetic;
  logic        rotate;
  logic        tieoff;

  // Funnel halves and shift amount
  word_t       fun_lo;
  word_t       fun_hi;
  logic [5:0]  shamt;
  logic [63:0] funnel;
  word_t       onehot_hit;

  assign rshift     = (req_i.op == ALU_SRL) || (req_i.op == ALU_SRA) || (req_i.op == ALU_ROR);
  assign arithmetic = (req_i.op == ALU_SRA);
  assign rotate     = (req_i.op == ALU_ROL) || (req_i.op == ALU_ROR);
  assign tieoff     = (req_i.op == ALU_BSET) || (req_i.op == ALU_BCLR) ||
                      (req_i.op == ALU_BINV) || (req_i.op == ALU_BEXT);

  ////////////////////
  // Funnel setup
  ////////////////////

  // Only B mod 32 counts
  // Right shift is a left rotate by the negated amount
  assign shamt = rshift ? 6'd0 - {1'b0, req_i.b[4:0]} : {1'b0, req_i.b[4:0]};

  // Tie-off form shifts a single 1 to build the bit mask
  assign fun_lo = tieoff ? word_t'(1) : req_i.a;

  always_comb begin
    if (rotate) begin
      // Rotate wraps A back into itself
      fun_hi = req_i.a;
    end else if (arithmetic) begin
      fun_hi = {XLEN{req_i.a[XLEN-1]}};
    end else begin
      // Zero fill for logical shifts and the tie-off form
      fun_hi = '0;
    end
  end

  ////////////////////
  // Rotate stages
  ////////////////////

  always_comb begin
    funnel = {fun_hi, fun_lo};
    // Six stages from 32 down to 1
    for (int i = 5; i >= 0; i--) begin
      if (shamt[i]) begin
        funnel = (funnel << (1 << i)) | (funnel >> (64 - (1 << i)));
      end
    end
  end

  assign shift_result_o = funnel[XLEN-1:0];

  ////////////////////
  // Zbs results
  ////////////////////

  // Bit of A picked by the mask
  assign onehot_hit = req_i.a & shift_result_o;

  always_comb begin
    unique case (req_i.op)
      ALU_BSET: bit_result_o = req_i.a | shift_result_o;
      ALU_BCLR: bit_result_o = req_i.a & ~shift_result_o;
      ALU_BINV: bit_result_o = req_i.a ^ shift_result_o;
      // Extracted bit lands in the LSB
      ALU_BEXT: bit_result_o = {{(XLEN-1){1'b0}}, |onehot_hit};
      default:  bit_result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* src/alu_adder.sv */
// Module alu_adder: add, subtract and shift-by-1/2/3-then-add
`timescale 1ns/1ps
`default_nettype none

module alu_adder (
  input  alu_pkg::alu_req_t req_i,
  output alu_pkg::word_t    sum_o
);
  import alu_pkg::*;

  logic  negate;
  word_t op_a;
  word_t op_b;

  // Subtract as A + ~B + 1
  assign negate = (req_i.op == ALU_SUB);

  // Pre-shift of A for the Zba forms
  always_comb begin
    unique case (req_i.op)
      ALU_SH1ADD: op_a = req_i.a << 1;
      ALU_SH2ADD: op_a = req_i.a << 2;
      ALU_SH3ADD: op_a = req_i.a << 3;
      default:    op_a = req_i.a;
    endcase
  end

  assign op_b = negate ? ~req_i.b : req_i.b;

  // Carry-in completes the two's complement, carry-out dropped
  assign sum_o = op_a + op_b + word_t'(negate);

endmodule

`default_nettype wire

/* src/alu_compare.sv */
// Module alu_compare: equal/greater compare, branch and set-less-than bit, min and max select
`timescale 1ns/1ps
`default_nettype none

module alu_compare (
  input  alu_pkg::alu_req_t req_i,
  output logic              cmp_o,
  output alu_pkg::word_t    minmax_o
);
  import alu_pkg::*;

  logic cmp_signed;
  logic is_equal;
  logic is_greater;

  // Signed forms
  assign cmp_signed = (req_i.op == ALU_GES) || (req_i.op == ALU_LTS) ||
                      (req_i.op == ALU_SLTS) || (req_i.op == ALU_MIN) ||
                      (req_i.op == ALU_MAX);

  assign is_equal = (req_i.a == req_i.b);

  // 33-bit compare, top bit is the sign only in signed mode
  assign is_greater = $signed({req_i.a[XLEN-1] & cmp_signed, req_i.a}) >
                      $signed({req_i.b[XLEN-1] & cmp_signed, req_i.b});

  ////////////////////
  // Compare bit
  ////////////////////

  always_comb begin
    unique case (req_i.op)
      ALU_NE:   cmp_o = ~is_equal;
      ALU_GES,
      ALU_GEU:  cmp_o = is_greater | is_equal;
      // Less than is neither greater nor equal
      ALU_LTS,
      ALU_LTU,
      ALU_SLTS,
      ALU_SLTU: cmp_o = ~(is_greater | is_equal);
      // EQ and every op without a compare
      default:  cmp_o = is_equal;
    endcase
  end

  ////////////////////
  // Min and max
  ////////////////////

  always_comb begin
    unique case (req_i.op)
      ALU_MAX,
      ALU_MAXU: minmax_o = is_greater ? req_i.a : req_i.b;
      // MIN and MINU, also the idle value
      default:  minmax_o = is_greater ? req_i.b : req_i.a;
    endcase
  end

endmodule

`default_nettype wire

/* src/alu_bitcount.sv */
// Module alu_bitcount: count leading zeros, count trailing zeros and population count
`timescale 1ns/1ps
`default_nettype none

module alu_bitcount (
  input  alu_pkg::alu_req_t req_i,
  output alu_pkg::count_t   count_o
);
  import alu_pkg::*;

  word_t  a_rev;
  word_t  scan_data;
  count_t lead_zeros;
  count_t ones;

  // Bit reversal turns CTZ into CLZ
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      a_rev[i] = req_i.a[XLEN-1-i];
    end
  end

  assign scan_data = (req_i.op == ALU_CTZ) ? a_rev : req_i.a;

  ////////////////////
  // First one
  ////////////////////

  // Highest set bit wins since it is assigned last
  always_comb begin
    lead_zeros = count_t'(XLEN);
    for (int i = 0; i < XLEN; i++) begin
      if (scan_data[i]) begin
        lead_zeros = count_t'(XLEN - 1 - i);
      end
    end
  end

  ////////////////////
  // Popcount
  ////////////////////

  always_comb begin
    ones = '0;
    for (int i = 0; i < XLEN; i++) begin
      ones = ones + count_t'(req_i.a[i]);
    end
  end

  // CLZ and CTZ share the scanner
  assign count_o = (req_i.op == ALU_CPOP) ? ones : lead_zeros;

endmodule

`default_nettype wire

/* src/alu_result_stage.sv */
// Module alu_result_stage: logic and byte ops, result select by opcode, response register
`timescale 1ns/1ps
`default_nettype none

module alu_result_stage (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              req_valid_i,
  input  alu_pkg::alu_req_t req_i,
  input  alu_pkg::word_t    shift_result_i,
  input  alu_pkg::word_t    bit_result_i,
  input  alu_pkg::word_t    sum_i,
  input  logic              cmp_i,
  input  alu_pkg::word_t    minmax_i,
  input  alu_pkg::count_t   count_i,
  output logic              rsp_valid_o,
  output alu_pkg::alu_rsp_t rsp_o
);
  import alu_pkg::*;

  word_t    a;
  word_t    b;
  word_t    orc_b;
  word_t    rev8;
  alu_rsp_t rsp_d;

  assign a = req_i.a;
  assign b = req_i.b;

  ////////////////////
  // Byte ops
  ////////////////////

  // Byte becomes all ones if any bit is set
  always_comb begin
    for (int i = 0; i < XLEN / 8; i++) begin
      orc_b[8*i +: 8] = {8{|a[8*i +: 8]}};
    end
  end

  // Byte order swapped
  always_comb begin
    for (int i = 0; i < XLEN / 8; i++) begin
      rev8[8*i +: 8] = a[XLEN-8-8*i +: 8];
    end
  end

  ////////////////////
  // Result select
  ////////////////////

  always_comb begin
    rsp_d.cmp = cmp_i;
    unique case (req_i.op)
      ALU_AND:    rsp_d.result = a & b;
      ALU_OR:     rsp_d.result = a | b;
      ALU_XOR:    rsp_d.result = a ^ b;
      ALU_ANDN:   rsp_d.result = a & ~b;
      ALU_ORN:    rsp_d.result = a | ~b;
      ALU_XNOR:   rsp_d.result = ~(a ^ b);
      // Adder
      ALU_ADD,
      ALU_SUB,
      ALU_SH1ADD,
      ALU_SH2ADD,
      ALU_SH3ADD: rsp_d.result = sum_i;
      // Shifter
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_ROL,
      ALU_ROR:    rsp_d.result = shift_result_i;
      ALU_BSET,
      ALU_BCLR,
      ALU_BINV,
      ALU_BEXT:   rsp_d.result = bit_result_i;
      // Set-less-than, zero-extended
      ALU_SLTS,
      ALU_SLTU:   rsp_d.result = {{(XLEN-1){1'b0}}, cmp_i};
      ALU_MIN,
      ALU_MINU,
      ALU_MAX,
      ALU_MAXU:   rsp_d.result = minmax_i;
      // Counters, zero-extended
      ALU_CLZ,
      ALU_CTZ,
      ALU_CPOP:   rsp_d.result = {{(XLEN-6){1'b0}}, count_i};
      ALU_ORC_B:  rsp_d.result = orc_b;
      ALU_REV8:   rsp_d.result = rev8;
      ALU_SEXT_B: rsp_d.result = {{(XLEN-8){a[7]}}, a[7:0]};
      ALU_SEXT_H: rsp_d.result = {{(XLEN-16){a[15]}}, a[15:0]};
      // Branch compares carry no result word
      default:    rsp_d.result = '0;
    endcase
  end

  ////////////////////
  // Output register
  ////////////////////

  // One cycle of latency, response held between requests
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
      rsp_o       <= '0;
    end else begin
      rsp_valid_o <= req_valid_i;
      if (req_valid_i) begin
        rsp_o <= rsp_d;
      end
    end
  end

endmodule

`default_nettype wire

/* src/alu_top.sv */
// Module alu_top: ALU top level with shifter, adder, compare, bit counter and result stage
`timescale 1ns/1ps
`default_nettype none

module alu_top (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              req_valid_i,
  input  alu_pkg::alu_req_t req_i,
  output logic              rsp_valid_o,
  output alu_pkg::alu_rsp_t rsp_o
);
  import alu_pkg::*;

  // Unit results into the result stage
  word_t  shift_result;
  word_t  bit_result;
  word_t  sum;
  logic   cmp;
  word_t  minmax;
  count_t count;

  ////////////////////
  // Datapath units
  ////////////////////

  alu_shifter u_shifter (
    .req_i          (req_i),
    .shift_result_o (shift_result),
    .bit_result_o   (bit_result)
  );

  alu_adder u_adder (
    .req_i (req_i),
    .sum_o (sum)
  );

  alu_compare u_compare (
    .req_i    (req_i),
    .cmp_o    (cmp),
    .minmax_o (minmax)
  );

  alu_bitcount u_bitcount (
    .req_i   (req_i),
    .count_o (count)
  );

  // Select and register
  alu_result_stage u_result_stage (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .shift_result_i (shift_result),
    .bit_result_i   (bit_result),
    .sum_i          (sum),
    .cmp_i          (cmp),
    .minmax_i       (minmax),
    .count_i        (count),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_o          (rsp_o)
  );

endmodule

`default_nettype wire

/* test/alu_checker.sv */
// Request monitor, reference model, expected queue and response compare
`timescale 1ns/1ps
`default_nettype none

module alu_checker (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              req_valid_i,
  input  alu_pkg::alu_req_t req_i,
  input  logic              exp_from_file_i,
  input  alu_pkg::alu_rsp_t exp_rsp_i,
  input  logic              rsp_valid_i,
  input  alu_pkg::alu_rsp_t rsp_i,
  output int                checked_o,
  output int                value_errors_o,
  output int                valid_errors_o
);
  import alu_pkg::*;

  alu_rsp_t expected_q[$];
  // Last response the register should hold
  alu_rsp_t held = '0;
  alu_rsp_t want;
  // Request taken at the last rising edge
  logic     pending = 1'b0;

  ////////////////////
  // Reference model
  ////////////////////

  function automatic alu_rsp_t model_rsp(alu_req_t req);
    alu_rsp_t   rsp;
    word_t      a;
    word_t      b;
    logic [4:0] sh;
    logic       lt_s;
    logic       lt_u;
    int         n;
    a    = req.a;
    b    = req.b;
    sh   = b[4:0];
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    // Equality bit unless the op is a comparison
    rsp.cmp    = (a == b);
    rsp.result = '0;
    n          = 0;
    case (req.op)
      ALU_AND:    rsp.result = a & b;
      ALU_OR:     rsp.result = a | b;
      ALU_XOR:    rsp.result = a ^ b;
      ALU_ANDN:   rsp.result = a & ~b;
      ALU_ORN:    rsp.result = a | ~b;
      ALU_XNOR:   rsp.result = ~(a ^ b);
      ALU_ADD:    rsp.result = a + b;
      ALU_SUB:    rsp.result = a - b;
      ALU_SH1ADD: rsp.result = (a << 1) + b;
      ALU_SH2ADD: rsp.result = (a << 2) + b;
      ALU_SH3ADD: rsp.result = (a << 3) + b;
      ALU_SLL:    rsp.result = a << sh;
      ALU_SRL:    rsp.result = a >> sh;
      ALU_SRA:    rsp.result = $signed(a) >>> sh;
      ALU_ROL:    rsp.result = (a << sh) | (a >> (32 - sh));
      ALU_ROR:    rsp.result = (a >> sh) | (a << (32 - sh));
      ALU_BSET:   rsp.result = a | (word_t'(1) << sh);
      ALU_BCLR:   rsp.result = a & ~(word_t'(1) << sh);
      ALU_BINV:   rsp.result = a ^ (word_t'(1) << sh);
      ALU_BEXT:   rsp.result = word_t'(a[sh]);
      // Branch compares leave the result at zero
      ALU_NE:     rsp.cmp = (a != b);
      ALU_GES:    rsp.cmp = !lt_s;
      ALU_GEU:    rsp.cmp = !lt_u;
      ALU_LTS:    rsp.cmp = lt_s;
      ALU_LTU:    rsp.cmp = lt_u;
      ALU_SLTS: begin
        rsp.cmp    = lt_s;
        rsp.result = word_t'(lt_s);
      end
      ALU_SLTU: begin
        rsp.cmp    = lt_u;
        rsp.result = word_t'(lt_u);
      end
      ALU_MIN:    rsp.result = lt_s ? a : b;
      ALU_MINU:   rsp.result = lt_u ? a : b;
      ALU_MAX:    rsp.result = lt_s ? b : a;
      ALU_MAXU:   rsp.result = lt_u ? b : a;
      ALU_CLZ: begin
        while (n < XLEN && a[XLEN-1-n] == 1'b0) begin
          n++;
        end
        rsp.result = word_t'(n);
      end
      ALU_CTZ: begin
        while (n < XLEN && a[n] == 1'b0) begin
          n++;
        end
        rsp.result = word_t'(n);
      end
      ALU_CPOP:   rsp.result = word_t'($countones(a));
      ALU_ORC_B: begin
        for (int i = 0; i < 4; i++) begin
          rsp.result[8*i +: 8] = (a[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
        end
      end
      ALU_REV8:   rsp.result = {a[7:0], a[15:8], a[23:16], a[31:24]};
      ALU_SEXT_B: rsp.result = word_t'($signed(a[7:0]));
      ALU_SEXT_H: rsp.result = word_t'($signed(a[15:0]));
      default:    rsp.result = '0;
    endcase
    return rsp;
  endfunction

  ////////////////////
  // Request side
  ////////////////////

  initial begin
    checked_o      = 0;
    value_errors_o = 0;
    valid_errors_o = 0;
  end

  // Requests are driven on the falling edge and stable at the rising one
  always @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      expected_q.delete();
      pending = 1'b0;
      held    = '0;
    end else begin
      pending = req_valid_i;
      if (req_valid_i) begin
        expected_q.push_back(exp_from_file_i ? exp_rsp_i : model_rsp(req_i));
      end
    end
  end

  ////////////////////
  // Response side
  ////////////////////

  // Outputs settle after the rising edge and are compared at the falling one
  always @(negedge clk) begin
    if (rst_n_i) begin
      if (pending) begin
        if (rsp_valid_i !== 1'b1) begin
          $display("FAIL %0t rsp_valid_o expected 1 got %b", $time, rsp_valid_i);
          valid_errors_o++;
        end
        // One expected entry per request taken at the last rising edge
        want = expected_q.pop_front();
        checked_o++;
        if (rsp_i.result !== want.result) begin
          $display("FAIL %0t rsp_o.result expected %h got %h", $time, want.result,
                   rsp_i.result);
          value_errors_o++;
        end
        if (rsp_i.cmp !== want.cmp) begin
          $display("FAIL %0t rsp_o.cmp expected %b got %b", $time, want.cmp, rsp_i.cmp);
          value_errors_o++;
        end
        held = want;
      end else begin
        if (rsp_valid_i !== 1'b0) begin
          $display("FAIL %0t rsp_valid_o expected 0 got %b", $time, rsp_valid_i);
          valid_errors_o++;
        end
        // Idle cycle keeps the last response
        if (rsp_i !== held) begin
          $display("FAIL %0t rsp_o expected %h got %h", $time, held, rsp_i);
          value_errors_o++;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* test/alu_top_assert.sv */
// Module alu_top_assert: valid latency, hold and known-output properties, bound into alu_top
`timescale 1ns/1ps
`default_nettype none

module alu_top_assert (
  input logic              clk,
  input logic              rst_n_i,
  input logic              req_valid_i,
  input logic              rsp_valid_i,
  input alu_pkg::alu_rsp_t rsp_i
);

  // Failed assertions so far
  int fail_count = 0;

  // Valid follows the request strobe by exactly one cycle
  valid_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
    rsp_valid_i == $past(req_valid_i))
  else begin
    fail_count++;
    $error("rsp_valid_o does not match req_valid_i of the previous cycle");
  end

  // Response register keeps its value over idle cycles
  rsp_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    !$past(req_valid_i) |-> $stable(rsp_i))
  else begin
    fail_count++;
    $error("rsp_o changed in a cycle without a request");
  end

  // No X or Z on the outputs once out of reset
  rsp_known: assert property (@(posedge clk) disable iff (!rst_n_i)
    !$isunknown({rsp_valid_i, rsp_i}))
  else begin
    fail_count++;
    $error("unknown value on rsp_valid_o or rsp_o");
  end

endmodule

bind alu_top alu_top_assert u_alu_top_assert (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .req_valid_i (req_valid_i),
  .rsp_valid_i (rsp_valid_o),
  .rsp_i       (rsp_o)
);

`default_nettype wire

/* test/alu_tb.sv */
// Module alu_tb: clock, reset, pattern reader, request stimulus, watchdog and final report
`timescale 1ns/1ps
`default_nettype none

module alu_tb;
  import alu_pkg::*;

  localparam int    CLK_PERIOD   = 100;
  localparam int    RESET_CYCLES = 8;
  localparam int    RAND_COUNT   = 200;
  localparam int    MARGIN       = 100;
  localparam string PATTERN_FILE = "test/alu_patterns.txt";

  logic     clk;
  logic     rst_n_i;
  logic     req_valid_i;
  alu_req_t req_i;
  logic     rsp_valid_o;
  alu_rsp_t rsp_o;

  // Expected response for file lines, to the checker
  logic     exp_from_file;
  alu_rsp_t exp_rsp;

  // Pattern table from the file
  alu_req_t pat_req[$];
  alu_rsp_t pat_rsp[$];

  int checked;
  int value_errors;
  int valid_errors;
  int assert_errors;
  int file_errors;
  int sent_count;
  int cycle_count;
  int cycle_limit = 0;

  alu_top uut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  alu_checker u_checker (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .exp_from_file_i (exp_from_file),
    .exp_rsp_i       (exp_rsp),
    .rsp_valid_i     (rsp_valid_o),
    .rsp_i           (rsp_o),
    .checked_o       (checked),
    .value_errors_o  (value_errors),
    .valid_errors_o  (valid_errors)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic read_patterns();
    int       fd;
    int       fields;
    int       op;
    int       cmp;
    word_t    a;
    word_t    b;
    word_t    result;
    string    line;
    alu_req_t req;
    alu_rsp_t rsp;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("ERROR cannot open pattern file %s", PATTERN_FILE);
      file_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Skip comment lines
      if (line.len() == 0 || line.substr(0, 0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%d %h %h %h %d", op, a, b, result, cmp);
      if (fields == 5) begin
        req.op     = alu_op_e'(op);
        req.a      = a;
        req.b      = b;
        rsp.result = result;
        rsp.cmp    = cmp[0];
        pat_req.push_back(req);
        pat_rsp.push_back(rsp);
      end else if (fields > 0) begin
        $display("ERROR malformed line in pattern file: %s", line);
        file_errors++;
      end
    end
    $fclose(fd);
  endtask

  // Drive one request on the falling edge
  task automatic send_request(input alu_req_t req, input logic from_file, input alu_rsp_t rsp);
    @(negedge clk);
    req_valid_i   = 1'b1;
    req_i         = req;
    exp_from_file = from_file;
    exp_rsp       = rsp;
    sent_count++;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    req_valid_i   = 1'b0;
    exp_from_file = 1'b0;
  endtask

  function automatic alu_req_t random_request();
    alu_req_t req;
    req.op = alu_op_e'($urandom_range(38, 0));
    req.a  = $urandom();
    req.b  = $urandom();
    // Sign boundary, equal operands and sparse words for the counters
    if ($urandom_range(7, 0) == 0) begin
      req.a = 32'h8000_0000;
    end
    if ($urandom_range(7, 0) == 0) begin
      req.b = req.a;
    end
    if ($urandom_range(7, 0) == 0) begin
      req.a = req.a >> $urandom_range(31, 0);
    end
    if ($urandom_range(15, 0) == 0) begin
      req.a = '0;
    end
    return req;
  endfunction

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    cycle_count = 0;
    while (cycle_limit == 0 || cycle_count <= cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles with %0d of %0d responses checked",
             cycle_count, checked, sent_count);
    $display("tests failed");
    $finish;
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rst_n_i       = 1'b0;
    req_valid_i   = 1'b0;
    req_i         = '0;
    exp_from_file = 1'b0;
    exp_rsp       = '0;
    sent_count    = 0;
    file_errors   = 0;
    void'($urandom(13905));
    read_patterns();
    // Reset, lead-in idles, patterns, random requests with at most one idle each
    cycle_limit = RESET_CYCLES + 2 + pat_req.size() + 2 * RAND_COUNT + MARGIN;

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n_i = 1'b1;
    // Outputs checked idle before the first request
    repeat (2) @(negedge clk);

    foreach (pat_req[i]) begin
      send_request(pat_req[i], 1'b1, pat_rsp[i]);
    end
    for (int i = 0; i < RAND_COUNT; i++) begin
      send_request(random_request(), 1'b0, '0);
      if ($urandom_range(3, 0) == 0) begin
        idle_cycle();
      end
    end
    idle_cycle();

    // Wait until the checker has seen every response
    while (checked < sent_count) begin
      @(posedge clk);
    end
    @(posedge clk);

    assert_errors = uut.u_alu_top_assert.fail_count;
    $display("Checked %0d of %0d: %0d value, %0d valid, %0d assertion, %0d file errors",
             checked, sent_count, value_errors, valid_errors, assert_errors, file_errors);
    if (value_errors + valid_errors + assert_errors + file_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
src/alu_pkg.sv
src/alu_shifter.sv
src/alu_adder.sv
src/alu_compare.sv
src/alu_bitcount.sv
src/alu_result_stage.sv
src/alu_top.sv
test/alu_checker.sv
test/alu_top_assert.sv
test/alu_tb.sv

/* test/alu_patterns.txt */
# Columns: opcode (decimal), operand A (hex), operand B (hex), result (hex), cmp bit
# cmp is the equality bit for opcodes without a comparison
3 7fffffff 00000001 80000000 0
4 00000000 00000001 ffffffff 0
16 00000003 00000010 00000016 0
17 40000001 00000001 00000005 0
18 00000010 00000008 00000088 0
0 f0f0f0f0 ff00ff00 f000f000 0
1 f0f0f0f0 0f0f0000 fffff0f0 0
2 aaaaaaaa ffffffff 55555555 0
26 ffff0000 ff00ff00 00ff0000 0
27 00000000 0000ffff ffff0000 0
28 12345678 12345678 ffffffff 1
5 00000001 00000021 00000002 0
6 80000000 00000004 08000000 0
7 80000000 0000001f ffffffff 0
31 80000001 00000001 00000003 0
32 00000001 00000001 80000000 1
35 00000000 0000001f 80000000 0
36 ffffffff 00000000 fffffffe 0
37 0000000f 00000023 00000007 0
38 00000100 00000008 00000001 0
10 00000005 00000005 00000000 1
11 00000005 00000006 00000000 1
12 ffffffff 00000001 00000000 0
13 ffffffff 00000001 00000000 1
14 80000000 7fffffff 00000000 1
15 80000000 7fffffff 00000000 0
8 ffffffff 00000000 00000001 1
9 ffffffff 00000000 00000000 0
22 80000000 00000001 80000000 0
23 80000000 00000001 00000001 0
24 80000000 00000001 00000001 0
25 80000000 00000001 80000000 0
19 00000000 00000000 00000020 1
20 00000000 00000000 00000020 1
20 00010000 00000000 00000010 0
21 0f0f0001 00000000 00000009 0
29 00100080 00000000 00ff00ff 0
30 12345678 00000000 78563412 0
33 00000080 00000000 ffffff80 0
34 00008001 00000000 ffff8001 0
